//--- hdl/uart_defines.svh
// UART build constants
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// System clock in Hz
`define UART_CLOCK_FREQUENCY 10_000_000

// Serial line rate in bits per second
`define UART_BAUD_RATE 625_000

// Clocks between baud ticks
// Four ticks per bit, so a bit is 4 * UART_CLKS_PER_TICK clocks
`define UART_CLKS_PER_TICK (`UART_CLOCK_FREQUENCY / (4 * `UART_BAUD_RATE))

// FIFO address width
// Depth is 2**UART_FIFO_DEPTH_LOG2 bytes
`define UART_FIFO_DEPTH_LOG2 2

// Frame format is fixed
// 8 data bits, no parity, one stop bit
`define UART_DATA_BITS 8

`endif

//--- hdl/uart_pkg.sv
// UART shared types
package uart_pkg;

    // Transmitter states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    // Receiver states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef struct packed {
        logic empty;
        logic full;
    } fifo_flags_t;

    // CPU-visible status byte, tx_ready in bit 0
    typedef struct packed {
        logic [3:0] reserved;
        logic       rx_error;
        logic       rx_avail;
        logic       tx_empty;
        logic       tx_ready;
    } uart_status_t;

endpackage

//--- hdl/uart_fifo.sv
// Byte FIFO, first word fall through
`timescale 1ns/1ns

module uart_fifo #(
    parameter int DEPTH_LOG2 = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  logic                   pop,
    input  logic [7:0]             wdata,
    output logic [7:0]             rdata,
    output uart_pkg::fifo_flags_t  flags
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    logic [7:0]            mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  do_push;
    logic                  do_pop;

    assign flags.empty = (count == '0);
    assign flags.full  = (count == (DEPTH_LOG2 + 1)'(DEPTH));

    // Overflow and underflow requests are dropped
    assign do_push = push && !flags.full;
    assign do_pop  = pop && !flags.empty;

    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/uart_baud_timer.sv
// Baud tick generator
`timescale 1ns/1ns
`include "uart_defines.svh"

module uart_baud_timer (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CLKS = `UART_CLKS_PER_TICK;
    localparam int CW   = (CLKS > 1) ? $clog2(CLKS) : 1;

    logic [CW-1:0] count;

    // Free running, one pulse per wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            tick <= (count == CW'(CLKS - 1));
            if (count == CW'(CLKS - 1)) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

//--- hdl/uart_tx.sv
// UART transmitter
`timescale 1ns/1ns

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       start,
    input  logic [7:0] byte_in,
    output logic       busy,
    output logic       txd
);

    uart_pkg::tx_state_e state;
    logic [1:0]          phase;
    logic [2:0]          bit_idx;
    logic [7:0]          shreg;

    assign busy = (state != uart_pkg::TX_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= uart_pkg::TX_IDLE;
            phase   <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (start) begin
                        shreg <= byte_in;
                        txd   <= 1'b0;
                        phase <= '0;
                        state <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (tick) begin
                        phase <= phase + 1'b1;
                        if (phase == 2'd3) begin
                            txd     <= shreg[0];
                            bit_idx <= '0;
                            state   <= uart_pkg::TX_DATA;
                        end
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (tick) begin
                        phase <= phase + 1'b1;
                        if (phase == 2'd3) begin
                            // LSB first, shift toward bit 0
                            if (bit_idx == 3'd7) begin
                                txd   <= 1'b1;
                                state <= uart_pkg::TX_STOP;
                            end else begin
                                shreg   <= shreg >> 1;
                                txd     <= shreg[1];
                                bit_idx <= bit_idx + 1'b1;
                            end
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (tick) begin
                        phase <= phase + 1'b1;
                        if (phase == 2'd3) begin
                            state <= uart_pkg::TX_IDLE;
                        end
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/uart_rx.sv
// UART receiver
`timescale 1ns/1ns

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       rxd,
    output logic       done,
    output logic       frame_err,
    output logic [7:0] byte_out
);

    uart_pkg::rx_state_e state;
    logic [1:0]          sync;
    logic                rxd_s;
    logic [1:0]          phase;
    logic [2:0]          bit_idx;
    logic [7:0]          shreg;

    // Two-flop synchronizer, idle high
    always_ff @(posedge clk) begin
        if (rst) begin
            sync <= 2'b11;
        end else begin
            sync <= {sync[0], rxd};
        end
    end

    assign rxd_s    = sync[1];
    assign byte_out = shreg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= uart_pkg::RX_IDLE;
            phase     <= '0;
            bit_idx   <= '0;
            done      <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            done      <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (tick && !rxd_s) begin
                        phase <= '0;
                        state <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    if (tick) begin
                        phase <= phase + 1'b1;
                        // Second tick after detection is mid start bit
                        if (phase == 2'd1) begin
                            phase <= '0;
                            if (rxd_s) begin
                                state <= uart_pkg::RX_IDLE;
                            end else begin
                                bit_idx <= '0;
                                state   <= uart_pkg::RX_DATA;
                            end
                        end
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (tick) begin
                        phase <= phase + 1'b1;
                        if (phase == 2'd3) begin
                            shreg   <= {rxd_s, shreg[7:1]};
                            bit_idx <= bit_idx + 1'b1;
                            if (bit_idx == 3'd7) begin
                                state <= uart_pkg::RX_STOP;
                            end
                        end
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (tick) begin
                        phase <= phase + 1'b1;
                        if (phase == 2'd3) begin
                            // Low stop bit means a broken frame
                            done      <= rxd_s;
                            frame_err <= !rxd_s;
                            state     <= uart_pkg::RX_IDLE;
                        end
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/uart_controller.sv
// UART controller top level
`timescale 1ns/1ns
`include "uart_defines.svh"

module uart_controller (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rx,
    input  logic                   wr_en,
    input  logic                   read,
    input  logic [15:0]            data,
    output logic [7:0]             data_out,
    output uart_pkg::uart_status_t status_out,
    output logic                   tx,
    output logic                   uart_wait
);

    uart_pkg::fifo_flags_t tx_flags;
    uart_pkg::fifo_flags_t rx_flags;
    logic [7:0]            tx_head;
    logic [7:0]            rx_byte;
    logic                  tx_push;
    logic                  tx_pop;
    logic                  tx_start;
    logic                  tx_busy;
    logic                  rx_push;
    logic                  rx_pop;
    logic                  rx_done;
    logic                  rx_frame_err;
    logic                  tick;

    // CPU side, only the low data byte is sent
    assign tx_push = wr_en && !tx_flags.full;
    assign rx_pop  = read && !rx_flags.empty;

    // Serial side, start and pop share one cycle
    assign tx_start = !tx_flags.empty && !tx_busy;
    assign tx_pop   = tx_start;
    assign rx_push  = rx_done && !rx_flags.full;

    uart_fifo #(.DEPTH_LOG2(`UART_FIFO_DEPTH_LOG2)) tx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (tx_push),
        .pop   (tx_pop),
        .wdata (data[7:0]),
        .rdata (tx_head),
        .flags (tx_flags)
    );

    uart_fifo #(.DEPTH_LOG2(`UART_FIFO_DEPTH_LOG2)) rx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (rx_push),
        .pop   (rx_pop),
        .wdata (rx_byte),
        .rdata (data_out),
        .flags (rx_flags)
    );

    uart_baud_timer baud_i (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_tx tx_i (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .start   (tx_start),
        .byte_in (tx_head),
        .busy    (tx_busy),
        .txd     (tx)
    );

    uart_rx rx_i (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .rxd       (rx),
        .done      (rx_done),
        .frame_err (rx_frame_err),
        .byte_out  (rx_byte)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            status_out <= '0;
            uart_wait  <= 1'b0;
        end else begin
            // Refused write raises wait, accepted write clears it
            if (wr_en) begin
                uart_wait <= tx_flags.full;
            end
            status_out.reserved <= '0;
            status_out.tx_ready <= !tx_flags.full;
            status_out.tx_empty <= tx_flags.empty;
            status_out.rx_avail <= !rx_flags.empty;
            // Sticky until the next read strobe
            if (rx_frame_err) begin
                status_out.rx_error <= 1'b1;
            end else if (read) begin
                status_out.rx_error <= 1'b0;
            end
        end
    end

endmodule

//--- testbench/uart_controller_props.sv
// UART controller assertions
`timescale 1ns/1ns

module uart_controller_props (
    input logic                  clk,
    input logic                  rst,
    input logic                  tx,
    input logic                  tx_busy,
    input logic                  tx_start,
    input logic                  tx_push,
    input logic                  tx_pop,
    input logic                  rx_push,
    input logic                  rx_pop,
    input uart_pkg::fifo_flags_t tx_flags,
    input uart_pkg::fifo_flags_t rx_flags
);

    // Line rests high between frames
    tx_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx)
        else $error("tx low while the transmitter is idle");

    // A push shows as not empty on the next cycle
    tx_fifo_push: assert property (@(posedge clk) disable iff (rst)
        tx_push |=> !tx_flags.empty)
        else $error("transmit FIFO still empty after a push");

    tx_fifo_pop: assert property (@(posedge clk) disable iff (rst)
        tx_pop && !tx_push |=> !tx_flags.full)
        else $error("transmit FIFO still full after a pop");

    rx_fifo_push: assert property (@(posedge clk) disable iff (rst)
        rx_push |=> !rx_flags.empty)
        else $error("receive FIFO still empty after a push");

    rx_fifo_pop: assert property (@(posedge clk) disable iff (rst)
        rx_pop && !rx_push |=> !rx_flags.full)
        else $error("receive FIFO still full after a pop");

    // Busy must follow a start pulse, which keeps start from repeating
    start_then_busy: assert property (@(posedge clk) disable iff (rst) tx_start |=> tx_busy)
        else $error("transmitter not busy after a start pulse");

endmodule

//--- testbench/uart_controller_tb.sv
// UART controller testbench
`timescale 1ns/1ns
`include "uart_defines.svh"

module uart_controller_tb;

    localparam int FIFO_DEPTH    = 2 ** `UART_FIFO_DEPTH_LOG2;
    localparam int BIT_CLKS      = 16;
    localparam int FRAME_TIMEOUT = 400;

    logic                   clk;
    logic                   rst;
    logic                   rx;
    logic                   wr_en;
    logic                   read;
    logic [15:0]            data;
    logic [7:0]             data_out;
    uart_pkg::uart_status_t status_out;
    logic                   tx;
    logic                   uart_wait;

    logic [7:0] tx_bytes [6];
    logic [7:0] rx_model [$];
    logic       rx_err_model;
    logic [7:0] seen_byte;
    logic       seen_stop;
    int         idx;

    uart_controller dut_i (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .wr_en      (wr_en),
        .read       (read),
        .data       (data),
        .data_out   (data_out),
        .status_out (status_out),
        .tx         (tx),
        .uart_wait  (uart_wait)
    );

    bind uart_controller uart_controller_props props_i (
        .clk      (clk),
        .rst      (rst),
        .tx       (tx),
        .tx_busy  (tx_busy),
        .tx_start (tx_start),
        .tx_push  (tx_push),
        .tx_pop   (tx_pop),
        .rx_push  (rx_push),
        .rx_pop   (rx_pop),
        .tx_flags (tx_flags),
        .rx_flags (rx_flags)
    );

    always #50 clk = ~clk;

    // Status byte as the CPU should see it for the given model state
    function automatic uart_pkg::uart_status_t expected_status(input int tx_count,
                                                               input int rx_count,
                                                               input logic err);
        uart_pkg::uart_status_t s;
        s          = '0;
        s.tx_ready = (tx_count < FIFO_DEPTH);
        s.tx_empty = (tx_count == 0);
        s.rx_avail = (rx_count > 0);
        s.rx_error = err;
        return s;
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check(input string name, input logic [7:0] expected,
                         input logic [7:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    // Consecutive write strobes with a random upper data byte
    task automatic write_burst(input int count);
        int i;
        next_cycle();
        for (i = 0; i < count; i++) begin
            wr_en = 1'b1;
            data  = {8'($urandom), tx_bytes[i]};
            next_cycle();
        end
        wr_en = 1'b0;
    endtask

    task automatic read_strobe();
        read = 1'b1;
        next_cycle();
        read = 1'b0;
    endtask

    // Sample the line at mid-bit from the falling start edge
    task automatic decode_frame(output logic [7:0] value, output logic stop);
        int n;
        int i;
        n = 0;
        @(negedge clk);
        while (tx !== 1'b0) begin
            n++;
            if (n > FRAME_TIMEOUT) begin
                $display("No start bit seen on tx within %0d cycles", FRAME_TIMEOUT);
                abort_run();
            end
            @(negedge clk);
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            value[i] = tx;
        end
        repeat (BIT_CLKS) @(negedge clk);
        stop = tx;
    endtask

    task automatic expect_no_frame(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                $display("Unexpected frame on tx after the transmit FIFO drained");
                abort_run();
            end
        end
    endtask

    // One frame on rx followed by one idle bit
    task automatic send_frame(input logic [7:0] value, input logic stop);
        int i;
        next_cycle();
        rx = 1'b0;
        repeat (BIT_CLKS) next_cycle();
        for (i = 0; i < 8; i++) begin
            rx = value[i];
            repeat (BIT_CLKS) next_cycle();
        end
        rx = stop;
        repeat (BIT_CLKS) next_cycle();
        rx = 1'b1;
        repeat (BIT_CLKS) next_cycle();
    endtask

    task automatic wait_rx_flag(input string what, input logic error_flag);
        int n;
        n = 0;
        while ((error_flag ? status_out.rx_error : status_out.rx_avail) !== 1'b1) begin
            if (n == FRAME_TIMEOUT) begin
                $display("Timed out waiting for %s in the status byte", what);
                abort_run();
            end
            n++;
            next_cycle();
        end
    endtask

    initial begin
        void'($urandom(96389));
        clk          = 1'b0;
        rst          = 1'b1;
        rx           = 1'b1;
        wr_en        = 1'b0;
        read         = 1'b0;
        data         = '0;
        rx_err_model = 1'b0;
        repeat (10) next_cycle();
        rst = 1'b0;
        next_cycle();

        check("reset tx", 8'h01, 8'(tx));
        check("reset uart_wait", 8'h00, 8'(uart_wait));
        check("reset status", expected_status(0, 0, 1'b0), status_out);

        // Three frames in write order
        for (idx = 0; idx < 6; idx++) begin
            tx_bytes[idx] = 8'($urandom);
        end
        fork
            write_burst(3);
            for (idx = 0; idx < 3; idx++) begin
                decode_frame(seen_byte, seen_stop);
                check("tx order byte", tx_bytes[idx], seen_byte);
                check("tx order stop bit", 8'h01, 8'(seen_stop));
            end
        join
        check("tx_empty after frames", expected_status(0, 0, 1'b0), status_out);
        expect_no_frame(2 * BIT_CLKS);

        // One byte in flight and a full FIFO drop the last write
        for (idx = 0; idx < 6; idx++) begin
            tx_bytes[idx] = 8'($urandom);
        end
        fork
            begin
                write_burst(FIFO_DEPTH + 2);
                check("uart_wait after full write", 8'h01, 8'(uart_wait));
                check("status while full", expected_status(FIFO_DEPTH, 0, 1'b0), status_out);
            end
            for (idx = 0; idx < FIFO_DEPTH + 1; idx++) begin
                decode_frame(seen_byte, seen_stop);
                check("back-pressure byte", tx_bytes[idx], seen_byte);
                check("back-pressure stop bit", 8'h01, 8'(seen_stop));
            end
        join
        expect_no_frame(FRAME_TIMEOUT);
        check("status after drain", expected_status(0, 0, 1'b0), status_out);

        rx_model.push_back(8'($urandom));
        rx_model.push_back(8'($urandom));
        send_frame(rx_model[0], 1'b1);
        send_frame(rx_model[1], 1'b1);
        wait_rx_flag("rx_avail", 1'b0);
        check("first received byte", rx_model[0], data_out);
        read_strobe();
        rx_model.delete(0);
        check("second received byte", rx_model[0], data_out);
        read_strobe();
        rx_model.delete(0);
        next_cycle();
        check("status after reads", expected_status(0, rx_model.size(), rx_err_model),
              status_out);

        // Low stop bit
        send_frame(8'($urandom), 1'b0);
        rx_err_model = 1'b1;
        wait_rx_flag("rx_error", 1'b1);
        check("status after framing error",
              expected_status(0, rx_model.size(), rx_err_model), status_out);
        read_strobe();
        rx_err_model = 1'b0;
        check("status after error clear",
              expected_status(0, rx_model.size(), rx_err_model), status_out);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- build.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_baud_timer.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_controller.sv
testbench/uart_controller_props.sv
testbench/uart_controller_tb.sv

//--- Makefile
# Verilator flow for the UART controller testbench

TOP := uart_controller_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
